/* src/sinegen_defs.svh */
// ----------------------------------------------------------------------
// sine generator parameters
// channel count, sine table geometry, sample width and the Wishbone
// word addresses of the host register map
// ----------------------------------------------------------------------

`ifndef SINEGEN_DEFS_SVH
`define SINEGEN_DEFS_SVH

// one pulse output per correlator input
`define SG_NUM_CH 12

// entries in the shared sine table
`define SG_TABLE_LEN 100

// table distance between neighbouring channels
`define SG_PHASE_STEP (`SG_TABLE_LEN / `SG_NUM_CH)

// sample and PWM resolution in bits
`define SG_RES 8

// register map, word addresses
`define SG_ADR_CTRL   8'h00
`define SG_ADR_PRESC  8'h01
`define SG_ADR_STATUS 8'h02
// table entry n sits at this base plus n
`define SG_ADR_TABLE  8'h80

`endif

/* src/sinegen_pkg.sv */
// ----------------------------------------------------------------------
// sine generator types
// Wishbone request and response bundles, register views of the host
// write word, sequencer configuration and the per-channel samples
// ----------------------------------------------------------------------

`include "sinegen_defs.svh"

package sinegen_pkg;

	// master to slave
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [7:0]  adr;
		logic [31:0] dat;
	} wb_req_t;

	// slave to master
	typedef struct packed {
		logic        ack;
		logic [31:0] dat;
	} wb_rsp_t;

	// CTRL register layout
	typedef struct packed {
		logic [15:0] rsvd_hi;
		logic [7:0]  offset;
		logic [5:0]  rsvd_lo;
		logic        advance;
		logic        run;
	} ctrl_fields_t;

	// table write word, value in the low byte
	typedef struct packed {
		logic [23:0] rsvd;
		logic [7:0]  value;
	} table_entry_t;

	// the same bus word seen either as control fields or as a table entry
	typedef union packed {
		ctrl_fields_t ctrl;
		table_entry_t entry;
	} wb_wdata_u;

	typedef struct packed {
		logic        run;
		logic        advance;
		logic [7:0]  offset;
		logic [15:0] prescale;
	} seq_cfg_t;

	typedef struct packed {
		logic       wr;
		logic [6:0] idx;
		logic [7:0] value;
	} tbl_wr_t;

	// duty and overflow flag for every channel
	typedef struct packed {
		logic [`SG_NUM_CH-1:0][`SG_RES-1:0] duty;
		logic [`SG_NUM_CH-1:0]              ovf;
	} chan_sample_t;

endpackage

/* src/wb_reg_decode.sv */
// ----------------------------------------------------------------------
// Wishbone register decode
// classic slave with a single-cycle ack; holds CTRL and PRESC, routes
// table writes to the sequencer and returns register, status or table
// read data
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`include "sinegen_defs.svh"

module wb_reg_decode import sinegen_pkg::*; (
	input  logic       sin_clk,
	input  logic       rst_n,
	input  wb_req_t    wb_req,
	input  logic [6:0] phase_idx,
	input  logic [7:0] tbl_rdata,
	output wb_rsp_t    wb_rsp,
	output seq_cfg_t   cfg,
	output tbl_wr_t    tbl_wr,
	output logic [6:0] tbl_raddr
);

	logic         ack_q;
	logic [31:0]  rdat_q;
	logic [31:0]  rdat_d;
	logic         req_new;
	logic         wr_en;
	logic [7:0]   tbl_off;
	logic         tbl_hit;
	wb_wdata_u    wdata;
	ctrl_fields_t ctrl_rd;
	logic         run_q;
	logic         advance_q;
	logic [7:0]   offset_q;
	logic [15:0]  presc_q;

	// active cycle that has not been acknowledged yet
	assign req_new = wb_req.cyc & wb_req.stb & ~ack_q;
	assign wr_en = req_new & wb_req.we;
	assign wdata = wb_req.dat;

	// table window starts at the table base, 100 entries wide
	assign tbl_off = wb_req.adr - `SG_ADR_TABLE;
	assign tbl_hit = (wb_req.adr >= `SG_ADR_TABLE) && (tbl_off < 8'(`SG_TABLE_LEN));
	assign tbl_raddr = tbl_off[6:0];

	// one-cycle strobe towards the table, same edge as the ack
	assign tbl_wr.wr = wr_en & tbl_hit;
	assign tbl_wr.idx = tbl_off[6:0];
	assign tbl_wr.value = wdata.entry.value;

	always_ff @(posedge sin_clk) begin
		if (!rst_n) begin
			ack_q <= 1'b0;
			run_q <= 1'b0;
			advance_q <= 1'b0;
			offset_q <= '0;
			presc_q <= '0;
		end else begin
			ack_q <= req_new;
			if (wr_en && (wb_req.adr == `SG_ADR_CTRL)) begin
				run_q <= wdata.ctrl.run;
				advance_q <= wdata.ctrl.advance;
				offset_q <= wdata.ctrl.offset;
			end
			if (wr_en && (wb_req.adr == `SG_ADR_PRESC)) begin
				presc_q <= wb_req.dat[15:0];
			end
		end
	end

	// reserved control bits read back as zero
	always_comb begin
		ctrl_rd = '0;
		ctrl_rd.run = run_q;
		ctrl_rd.advance = advance_q;
		ctrl_rd.offset = offset_q;
	end

	always_comb begin
		rdat_d = '0;
		if (tbl_hit) begin
			rdat_d = {24'h0, tbl_rdata};
		end else begin
			case (wb_req.adr)
				`SG_ADR_CTRL:   rdat_d = ctrl_rd;
				`SG_ADR_PRESC:  rdat_d = {16'h0, presc_q};
				`SG_ADR_STATUS: rdat_d = {25'h0, phase_idx};
				default:        rdat_d = '0;
			endcase
		end
	end

	// read data is captured together with the ack
	always_ff @(posedge sin_clk) begin
		if (req_new) begin
			rdat_q <= rdat_d;
		end
	end

	assign wb_rsp.ack = ack_q;
	assign wb_rsp.dat = rdat_q;

	assign cfg.run = run_q;
	assign cfg.advance = advance_q;
	assign cfg.offset = offset_q;
	assign cfg.prescale = presc_q;

endmodule

/* src/phase_sequencer.sv */
// ----------------------------------------------------------------------
// phase sequencer
// stores the sine table, steps the phase index at the prescaled rate
// and looks up every channel at its own phase offset, flagging sums
// that do not fit in a sample
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`include "sinegen_defs.svh"

module phase_sequencer import sinegen_pkg::*; (
	input  logic         sin_clk,
	input  logic         rst_n,
	input  seq_cfg_t     cfg,
	input  tbl_wr_t      tbl_wr,
	input  logic [6:0]   tbl_raddr,
	output logic [6:0]   phase_idx,
	output logic [7:0]   tbl_rdata,
	output chan_sample_t samples,
	output logic         run
);

	logic [`SG_RES-1:0] sine_tbl [`SG_TABLE_LEN];
	logic [15:0]        tick_cnt;
	logic [6:0]         phase_q;
	logic               run_q;
	chan_sample_t       samples_d;
	chan_sample_t       samples_q;

	// table starts out empty, the host fills it in
	always_ff @(posedge sin_clk) begin
		if (!rst_n) begin
			for (int n = 0; n < `SG_TABLE_LEN; n++) begin
				sine_tbl[n] <= '0;
			end
		end else if (tbl_wr.wr) begin
			sine_tbl[tbl_wr.idx] <= tbl_wr.value;
		end
	end

	// host read port
	assign tbl_rdata = (tbl_raddr < 7'(`SG_TABLE_LEN)) ? sine_tbl[tbl_raddr] : '0;

	// phase steps once every prescale+1 cycles while advance is set,
	// index and tick count freeze otherwise
	always_ff @(posedge sin_clk) begin
		if (!rst_n) begin
			tick_cnt <= '0;
			phase_q <= '0;
			run_q <= 1'b0;
		end else begin
			run_q <= cfg.run;
			if (cfg.advance) begin
				if (tick_cnt >= cfg.prescale) begin
					tick_cnt <= '0;
					if (phase_q == 7'(`SG_TABLE_LEN - 1)) begin
						phase_q <= '0;
					end else begin
						phase_q <= phase_q + 7'd1;
					end
				end else begin
					tick_cnt <= tick_cnt + 16'd1;
				end
			end
		end
	end

	// channel i reads entry (phase + step*i) mod table length;
	// the largest raw index is below twice the length, so one subtract wraps it
	always_comb begin
		logic [7:0]        pos;
		logic [`SG_RES:0]  sum;
		samples_d = '0;
		for (int i = 0; i < `SG_NUM_CH; i++) begin
			pos = 8'(phase_q) + 8'(i * `SG_PHASE_STEP);
			if (pos >= 8'(`SG_TABLE_LEN)) begin
				pos = pos - 8'(`SG_TABLE_LEN);
			end
			sum = {1'b0, sine_tbl[pos[6:0]]} + {1'b0, cfg.offset};
			samples_d.duty[i] = sum[`SG_RES-1:0];
			// carry out of the sample width marks overflow
			samples_d.ovf[i] = sum[`SG_RES];
		end
	end

	always_ff @(posedge sin_clk) begin
		samples_q <= samples_d;
	end

	assign phase_idx = phase_q;
	assign samples = samples_q;
	assign run = run_q;

endmodule

/* src/pwm_bank.sv */
// ----------------------------------------------------------------------
// PWM bank
// one free-running 8-bit counter shared by all channels, compared
// against each channel's duty; overflowing channels stay low
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`include "sinegen_defs.svh"

module pwm_bank import sinegen_pkg::*; (
	input  logic                  sin_clk,
	input  logic                  rst_n,
	input  logic                  run,
	input  chan_sample_t          samples,
	output logic [`SG_NUM_CH-1:0] pulse_out
);

	logic [`SG_RES-1:0]    pwm_cnt;
	logic [`SG_NUM_CH-1:0] pulse_d;

	// counter wraps at 255 on its own, parked at 0 while stopped
	always_ff @(posedge sin_clk) begin
		if (!rst_n) begin
			pwm_cnt <= '0;
		end else if (run) begin
			pwm_cnt <= pwm_cnt + 1'b1;
		end else begin
			pwm_cnt <= '0;
		end
	end

	// high for exactly duty counts out of every 256
	always_comb begin
		for (int i = 0; i < `SG_NUM_CH; i++) begin
			pulse_d[i] = run && (pwm_cnt < samples.duty[i]) && !samples.ovf[i];
		end
	end

	always_ff @(posedge sin_clk) begin
		if (!rst_n) begin
			pulse_out <= '0;
		end else begin
			pulse_out <= pulse_d;
		end
	end

endmodule

/* src/sinegen_top.sv */
// ----------------------------------------------------------------------
// calibration sine generator
// host registers, phase sequencer with the sine table and the PWM
// bank that drives one pulse output per correlator input
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`include "sinegen_defs.svh"

module sinegen_top import sinegen_pkg::*; (
	input  logic                  sin_clk,
	input  logic                  rst_n,
	input  wb_req_t               wb_req,
	output wb_rsp_t               wb_rsp,
	output logic [`SG_NUM_CH-1:0] pulse_out
);

	seq_cfg_t     cfg;
	tbl_wr_t      tbl_wr;
	logic [6:0]   tbl_raddr;
	logic [7:0]   tbl_rdata;
	logic [6:0]   phase_idx;
	chan_sample_t samples;
	logic         run;

	wb_reg_decode u_decode (
		.sin_clk   (sin_clk),
		.rst_n     (rst_n),
		.wb_req    (wb_req),
		.phase_idx (phase_idx),
		.tbl_rdata (tbl_rdata),
		.wb_rsp    (wb_rsp),
		.cfg       (cfg),
		.tbl_wr    (tbl_wr),
		.tbl_raddr (tbl_raddr)
	);

	phase_sequencer u_execute (
		.sin_clk   (sin_clk),
		.rst_n     (rst_n),
		.cfg       (cfg),
		.tbl_wr    (tbl_wr),
		.tbl_raddr (tbl_raddr),
		.phase_idx (phase_idx),
		.tbl_rdata (tbl_rdata),
		.samples   (samples),
		.run       (run)
	);

	pwm_bank u_result (
		.sin_clk   (sin_clk),
		.rst_n     (rst_n),
		.run       (run),
		.samples   (samples),
		.pulse_out (pulse_out)
	);

endmodule

/* verification/tb_clock_gen.sv */
// ----------------------------------------------------------------------
// testbench clock and reset
// free-running sin_clk and a synchronous active-low reset that is
// released on a falling edge after a fixed number of cycles
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module tb_clock_gen #(
	parameter real period_ns  = 8.0,
	parameter int  rst_cycles = 10
) (
	output logic sin_clk,
	output logic rst_n
);

	initial begin
		sin_clk = 1'b0;
		forever #(period_ns / 2.0) sin_clk = ~sin_clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (rst_cycles) @(posedge sin_clk);
		@(negedge sin_clk);
		rst_n = 1'b1;
	end

endmodule

/* verification/sinegen_props.sv */
// ----------------------------------------------------------------------
// sine generator protocol properties
// Wishbone ack behaviour and pulse output quiescence, bound into the
// top level
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`include "sinegen_defs.svh"

module sinegen_props import sinegen_pkg::*; (
	input logic                  sin_clk,
	input logic                  rst_n,
	input wb_req_t               wb_req,
	input wb_rsp_t               wb_rsp,
	input logic [`SG_NUM_CH-1:0] pulse_out,
	input logic                  run
);

	int fail_cnt = 0;

	// ack is a single-cycle pulse
	ack_one_cycle: assert property (@(posedge sin_clk) disable iff (!rst_n)
		wb_rsp.ack |=> !wb_rsp.ack)
		else begin
			$error("ack held for more than one cycle");
			fail_cnt++;
		end

	// ack only answers an active request
	ack_after_req: assert property (@(posedge sin_clk) disable iff (!rst_n)
		wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
		else begin
			$error("ack without a preceding active request");
			fail_cnt++;
		end

	// a clear run bit reaches the outputs two cycles later
	quiet_when_stopped: assert property (@(posedge sin_clk) disable iff (!rst_n)
		!run |-> ##2 (pulse_out == '0))
		else begin
			$error("pulse output active while run is clear");
			fail_cnt++;
		end

	quiet_after_reset: assert property (@(posedge sin_clk)
		$rose(rst_n) |-> (pulse_out == '0))
		else begin
			$error("pulse output not cleared by reset");
			fail_cnt++;
		end

endmodule

bind sinegen_top sinegen_props u_props (
	.sin_clk   (sin_clk),
	.rst_n     (rst_n),
	.wb_req    (wb_req),
	.wb_rsp    (wb_rsp),
	.pulse_out (pulse_out),
	.run       (cfg.run)
);

/* verification/sinegen_tb.sv */
// ----------------------------------------------------------------------
// sine generator testbench
// random table, offset and phase settings over Wishbone, checked
// against a reference model of the registers, phase and PWM duty
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`include "sinegen_defs.svh"

module sinegen_tb import sinegen_pkg::*; ();

	localparam int ack_limit   = 16;
	localparam int settle      = 4;
	// worst-case cycles of the six tests, reset and a margin
	localparam int test_cycles = 20 + 650 + 600 + 600 + 450 + 80;
	localparam int watchdog_ns = (test_cycles + 10 + 500) * 8;

	logic                  sin_clk;
	logic                  rst_n;
	wb_req_t               wb_req;
	wb_rsp_t               wb_rsp;
	logic [`SG_NUM_CH-1:0] pulse_out;

	logic [31:0] lfsr;
	logic [7:0]  model_tbl [`SG_TABLE_LEN];
	logic [7:0]  model_offset;
	int          model_phase;
	int          err_cnt;
	int          chk_cnt;
	int          test_cnt;
	int          fail_tests;
	int          errs_before;

	tb_clock_gen #(.period_ns(8.0), .rst_cycles(10)) u_clk (.sin_clk(sin_clk), .rst_n(rst_n));

	sinegen_top uut (
		.sin_clk   (sin_clk),
		.rst_n     (rst_n),
		.wb_req    (wb_req),
		.wb_rsp    (wb_rsp),
		.pulse_out (pulse_out)
	);

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int b = 0; b < n; b++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [31:0] ctrl_word(input logic run, input logic adv,
			input logic [7:0] off);
		return {16'h0, off, 6'h0, adv, run};
	endfunction

	// high cycles per 256 expected on channel ch, zero on overflow
	function automatic int expected_duty(input int ch);
		int idx;
		int sum;
		idx = (model_phase + `SG_PHASE_STEP * ch) % `SG_TABLE_LEN;
		sum = model_tbl[idx] + model_offset;
		return (sum > 255) ? 0 : sum;
	endfunction

	task automatic check_eq(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("** Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
		end
	endtask

	// one classic cycle from a falling edge, then one idle cycle
	task automatic bus_cycle(input logic we, input logic [7:0] adr, input logic [31:0] dat,
			output logic [31:0] rdat);
		int lat;
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
		lat = 0;
		do begin
			@(negedge sin_clk);
			lat++;
		end while (!wb_rsp.ack && lat < ack_limit);
		if (!wb_rsp.ack) begin
			err_cnt++;
			$display("no ack within %0d cycles for address 0x%0h", ack_limit, adr);
		end else begin
			check_eq("ack latency", lat, 1);
		end
		rdat = wb_rsp.dat;
		wb_req = '0;
		@(negedge sin_clk);
	endtask

	task automatic bus_write(input logic [7:0] adr, input logic [31:0] dat);
		logic [31:0] unused;
		bus_cycle(1'b1, adr, dat, unused);
	endtask

	task automatic bus_read(input logic [7:0] adr, output logic [31:0] rdat);
		bus_cycle(1'b0, adr, 32'h0, rdat);
	endtask

	task automatic load_random_table();
		for (int n = 0; n < `SG_TABLE_LEN; n++) begin
			model_tbl[n] = rand_bits(8);
			bus_write(`SG_ADR_TABLE + 8'(n), {24'h0, model_tbl[n]});
		end
	endtask

	// count high cycles per channel over one full PWM period
	task automatic check_duty();
		int highs [`SG_NUM_CH];
		repeat (settle) @(negedge sin_clk);
		foreach (highs[i]) highs[i] = 0;
		repeat (256) begin
			@(negedge sin_clk);
			for (int i = 0; i < `SG_NUM_CH; i++) highs[i] += pulse_out[i];
		end
		for (int i = 0; i < `SG_NUM_CH; i++) begin
			check_eq($sformatf("pulse_out[%0d] high count", i), highs[i], expected_duty(i));
		end
	endtask

	task automatic finish_test(input string name);
		test_cnt++;
		if (err_cnt == errs_before) begin
			$display("%s: ok", name);
		end else begin
			fail_tests++;
			$display("%s: %0d errors", name, err_cnt - errs_before);
		end
		errs_before = err_cnt;
	endtask

	task automatic test_reset_values();
		logic [31:0] rd;
		check_eq("pulse_out", pulse_out, 0);
		bus_read(`SG_ADR_CTRL, rd);
		check_eq("CTRL", rd, 0);
		bus_read(`SG_ADR_PRESC, rd);
		check_eq("PRESC", rd, 0);
		bus_read(`SG_ADR_STATUS, rd);
		check_eq("STATUS", rd, 0);
		finish_test("reset values");
	endtask

	task automatic test_table_access();
		logic [31:0] rd;
		logic [7:0]  adr;
		load_random_table();
		for (int n = 0; n < `SG_TABLE_LEN; n++) begin
			bus_read(`SG_ADR_TABLE + 8'(n), rd);
			check_eq($sformatf("table[%0d]", n), rd, {24'h0, model_tbl[n]});
		end
		// entries 100 and up do not exist
		repeat (4) begin
			adr = 8'hE4 + 8'(rand_bits(4));
			bus_write(adr, rand_bits(8));
			bus_read(adr, rd);
			check_eq($sformatf("table address 0x%0h", adr), rd, 0);
		end
		finish_test("table access");
	endtask

	task automatic test_duty();
		logic [31:0] rd;
		load_random_table();
		model_offset = rand_bits(8);
		bus_write(`SG_ADR_CTRL, ctrl_word(1'b1, 1'b0, model_offset));
		bus_read(`SG_ADR_CTRL, rd);
		check_eq("CTRL", rd, ctrl_word(1'b1, 1'b0, model_offset));
		check_duty();
		finish_test("duty per channel");
	endtask

	task automatic test_phase_advance();
		logic [31:0] rd;
		int presc;
		int k;
		int wait_cycles;
		presc = rand_bits(2);
		k = 1 + rand_bits(7);
		bus_write(`SG_ADR_PRESC, presc);
		bus_read(`SG_ADR_PRESC, rd);
		check_eq("PRESC", rd, presc);
		bus_write(`SG_ADR_CTRL, ctrl_word(1'b1, 1'b1, model_offset));
		// one advancing edge has passed when the write returns
		wait_cycles = k * (presc + 1) - 1;
		repeat (wait_cycles) @(negedge sin_clk);
		bus_read(`SG_ADR_STATUS, rd);
		check_eq("STATUS", rd, k % `SG_TABLE_LEN);
		bus_write(`SG_ADR_CTRL, ctrl_word(1'b1, 1'b0, model_offset));
		// advance stays set through the edge of the clearing write
		model_phase = ((wait_cycles + 4) / (presc + 1)) % `SG_TABLE_LEN;
		repeat (8 + rand_bits(5)) @(negedge sin_clk);
		bus_read(`SG_ADR_STATUS, rd);
		check_eq("STATUS frozen", rd, model_phase);
		finish_test("phase advance");
	endtask

	task automatic test_phase_offset();
		logic [31:0] rd;
		int d;
		model_offset = rand_bits(8);
		d = rand_bits(7);
		// prescale zero steps the phase on every advancing edge
		bus_write(`SG_ADR_PRESC, 32'h0);
		bus_write(`SG_ADR_CTRL, ctrl_word(1'b1, 1'b1, model_offset));
		repeat (d) @(negedge sin_clk);
		bus_write(`SG_ADR_CTRL, ctrl_word(1'b1, 1'b0, model_offset));
		model_phase = (model_phase + d + 2) % `SG_TABLE_LEN;
		bus_read(`SG_ADR_STATUS, rd);
		check_eq("STATUS", rd, model_phase);
		check_duty();
		finish_test("phase offset lookup");
	endtask

	task automatic test_run_off();
		bus_write(`SG_ADR_CTRL, ctrl_word(1'b0, 1'b0, model_offset));
		@(negedge sin_clk);
		repeat (64) begin
			check_eq("pulse_out", pulse_out, 0);
			@(negedge sin_clk);
		end
		finish_test("run off");
	endtask

	initial begin
		#(watchdog_ns);
		$display("watchdog expired after %0d ns, the run did not finish", watchdog_ns);
		$display("Test failed");
		$finish;
	end

	initial begin
		wb_req = '0;
		lfsr = 32'h3c4bea15;
		model_offset = '0;
		model_phase = 0;
		err_cnt = 0;
		chk_cnt = 0;
		test_cnt = 0;
		fail_tests = 0;
		errs_before = 0;
		foreach (model_tbl[n]) model_tbl[n] = '0;
		@(posedge rst_n);
		@(negedge sin_clk);
		test_reset_values();
		test_table_access();
		test_duty();
		test_phase_advance();
		test_phase_offset();
		test_run_off();
		if (uut.u_props.fail_cnt != 0) begin
			$display("%0d protocol assertions failed", uut.u_props.fail_cnt);
			err_cnt += uut.u_props.fail_cnt;
		end
		$display("%0d tests, %0d with errors, %0d checks, %0d errors",
			test_cnt, fail_tests, chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* build.f */
+incdir+src
src/sinegen_pkg.sv
src/wb_reg_decode.sv
src/phase_sequencer.sv
src/pwm_bank.sv
src/sinegen_top.sv
verification/tb_clock_gen.sv
verification/sinegen_props.sv
verification/sinegen_tb.sv

/* Bender.yml */
package:
  name: sinegen

sources:
  - include_dirs:
      - src
    files:
      - src/sinegen_pkg.sv
      - src/wb_reg_decode.sv
      - src/phase_sequencer.sv
      - src/pwm_bank.sv
      - src/sinegen_top.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - verification/tb_clock_gen.sv
      - verification/sinegen_props.sv
      - verification/sinegen_tb.sv
